//--- verification/mem_subsys_testdata.txt
// kind store_addr store_data store_sel fill_addr exp_word0 exp_word1 exp_word2 exp_word3
// kind: 1 store, 2 fill from preload, 3 store and fill together, +4 fill words given here
2 00000000 0000 0 00001000 0000 0000 0000 0000
2 00000000 0000 0 0000123a 0000 0000 0000 0000
1 00001100 1111 3 00000000 0000 0000 0000 0000
1 00001102 2222 3 00000000 0000 0000 0000 0000
1 00001104 3333 3 00000000 0000 0000 0000 0000
1 00001106 4444 3 00000000 0000 0000 0000 0000
6 00000000 0000 0 00001100 1111 2222 3333 4444
1 00001102 abcd 1 00000000 0000 0000 0000 0000
1 00001106 9876 2 00000000 0000 0000 0000 0000
6 00000000 0000 0 00001104 1111 22cd 3333 9844
3 00001200 5a5a 3 00001300 0000 0000 0000 0000
2 00000000 0000 0 00001200 0000 0000 0000 0000
3 00001302 c3c3 2 00001400 0000 0000 0000 0000
2 00000000 0000 0 00001300 0000 0000 0000 0000
3 00001402 0f0f 1 00001500 0000 0000 0000 0000
2 00000000 0000 0 00001400 0000 0000 0000 0000
7 00001600 beef 3 00001106 1111 22cd 3333 9844
2 00000000 0000 0 00001600 0000 0000 0000 0000
1 00101ff8 7e81 3 00000000 0000 0000 0000 0000
2 00000000 0000 0 00101ffe 0000 0000 0000 0000

//--- src.f
design/procyon_mem_pkg.sv
design/wb_if.sv
design/mem_line_fill.sv
design/mem_store_drain.sv
design/wb_arbiter.sv
design/sram_wb.sv
design/mem_subsys_top.sv
verification/tb_clock_gen.sv
verification/mem_subsys_properties.sv
verification/mem_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_subsys_tb -f src.f -Mdir "$BUILD_DIR" -o mem_subsys_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

"./$BUILD_DIR/mem_subsys_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- verification/mem_subsys_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_tb;

    localparam int          LINE_WORDS   = 4;
    localparam logic [31:0] BASE_ADDR    = 32'h1000;
    localparam int          LINE_BYTES   = LINE_WORDS * 2;
    localparam int          IDX_W        = $clog2(LINE_WORDS);
    localparam int          SRAM_WORDS   = 1 << 20;
    localparam int          REC_WORDS    = 9;
    localparam int          MAX_CMDS     = 64;
    localparam int          RESET_CYCLES = 8;
    localparam logic [31:0] LCG_SEED     = 32'hd1cad543;

    logic             clk;
    logic             rst_n;
    logic             fill_req;
    logic [31:0]      fill_addr;
    logic             fill_valid;
    logic [15:0]      fill_data;
    logic [IDX_W-1:0] fill_index;
    logic             fill_done;
    logic             fill_busy;
    logic             store_en;
    logic [31:0]      store_addr;
    logic [15:0]      store_data;
    logic [1:0]       store_sel;
    logic             store_busy;
    logic             store_done;
    logic [15:0]      sram_dq_in;
    logic [15:0]      sram_dq_out;
    logic [19:0]      sram_addr;
    logic             sram_ce_n;
    logic             sram_oe_n;
    logic             sram_we_n;
    logic             sram_lb_n;
    logic             sram_ub_n;

    logic [15:0] sram_mem   [SRAM_WORDS];
    logic [15:0] shadow_mem [SRAM_WORDS];
    logic [31:0] cmd_mem    [MAX_CMDS * REC_WORDS];

    // Expected traffic for the commands in flight.
    logic [15:0] exp_fill_words [LINE_WORDS];
    logic [19:0] exp_fill_base;
    logic [19:0] exp_store_haddr;
    logic [15:0] exp_store_data;
    logic [1:0]  exp_store_sel;
    bit          fill_pending;
    bit          store_pending;
    int          fill_words_seen;
    int          fill_reads;
    int          store_writes;
    int          error_count;
    int          cycle_count;
    int          cycle_limit;
    int          n_cmds;

    tb_clock_gen clock_gen_inst (
        .o_clk(clk)
    );

    mem_subsys_top #(
        .LINE_WORDS(LINE_WORDS),
        .SRAM_BASE_ADDR(BASE_ADDR)
    ) mem_subsys_top_inst (
        .clk(clk),
        .i_rst_n(rst_n),
        .i_fill_req(fill_req),
        .i_fill_addr(fill_addr),
        .o_fill_valid(fill_valid),
        .o_fill_data(fill_data),
        .o_fill_index(fill_index),
        .o_fill_done(fill_done),
        .o_fill_busy(fill_busy),
        .i_store_en(store_en),
        .i_store_addr(store_addr),
        .i_store_data(store_data),
        .i_store_sel(store_sel),
        .o_store_busy(store_busy),
        .o_store_done(store_done),
        .i_sram_dq(sram_dq_in),
        .o_sram_dq(sram_dq_out),
        .o_sram_addr(sram_addr),
        .o_sram_ce_n(sram_ce_n),
        .o_sram_oe_n(sram_oe_n),
        .o_sram_we_n(sram_we_n),
        .o_sram_lb_n(sram_lb_n),
        .o_sram_ub_n(sram_ub_n)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Halfword index inside the SRAM window.
    function automatic logic [19:0] sram_index(input logic [31:0] byte_addr);
        logic [31:0] offset;
        offset = byte_addr - BASE_ADDR;
        return offset[20:1];
    endfunction

    function automatic logic [15:0] merge_lanes(input logic [15:0] old_word,
                                                input logic [15:0] new_word,
                                                input logic [1:0]  sel);
        logic [15:0] merged;
        merged = old_word;
        if (sel[0]) merged[7:0] = new_word[7:0];
        if (sel[1]) merged[15:8] = new_word[15:8];
        return merged;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    // Asynchronous SRAM, read path.
    assign sram_dq_in = (!sram_ce_n && !sram_oe_n) ? sram_mem[sram_addr] : 16'h0000;

    // One access per cycle of ce_n low; pins are stable at the falling edge.
    always @(negedge clk) begin
        if (rst_n && !sram_ce_n) begin
            if (!sram_we_n) begin
                check_value(store_pending, 1, "SRAM write with no store pending");
                check_value(sram_addr, exp_store_haddr, "SRAM write address");
                check_value(sram_dq_out, exp_store_data, "SRAM write data");
                check_value({sram_ub_n, sram_lb_n}, {~exp_store_sel[1], ~exp_store_sel[0]},
                            "SRAM write lanes");
                if (!sram_lb_n) sram_mem[sram_addr][7:0] = sram_dq_out[7:0];
                if (!sram_ub_n) sram_mem[sram_addr][15:8] = sram_dq_out[15:8];
                store_writes++;
            end else if (!sram_oe_n) begin
                check_value(fill_pending, 1, "SRAM read with no fill pending");
                check_value(sram_addr, exp_fill_base + 20'(fill_reads), "SRAM read address");
                check_value({sram_ub_n, sram_lb_n}, 2'b00, "SRAM read lanes");
                fill_reads++;
            end
        end
    end

    // Fill words and store completion.
    always @(negedge clk) begin
        if (rst_n) begin
            if (fill_valid) begin
                check_value(fill_pending, 1, "fill word with no fill pending");
                check_value(fill_index, fill_words_seen, "fill index");
                if (fill_words_seen < LINE_WORDS) begin
                    check_value(fill_data, exp_fill_words[fill_words_seen], "fill data");
                end
                check_value(fill_done, fill_words_seen == LINE_WORDS - 1, "fill done");
                fill_words_seen++;
                if (fill_done) fill_pending = 1'b0;
            end
            if (store_done) begin
                check_value(store_pending, 1, "store done with no store pending");
                store_pending = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Errors: %0d", error_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic load_commands();
        for (int i = 0; i < MAX_CMDS * REC_WORDS; i++) cmd_mem[i] = '0;
        $readmemh("verification/mem_subsys_testdata.txt", cmd_mem);
        n_cmds = 0;
        while (n_cmds < MAX_CMDS && cmd_mem[n_cmds * REC_WORDS] != 0) n_cmds++;
        if (n_cmds == 0) begin
            $display("No commands were read from the test data file");
            error_count++;
        end
    endtask

    task automatic preload_memory();
        logic [31:0] state;
        state = LCG_SEED;
        for (int i = 0; i < SRAM_WORDS; i++) begin
            state         = lcg_next(state);
            sram_mem[i]   = state[31:16];
            shadow_mem[i] = state[31:16];
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            #1;
            check_value(sram_ce_n, 1, "ce_n in reset");
            check_value(sram_oe_n, 1, "oe_n in reset");
            check_value(sram_we_n, 1, "we_n in reset");
            check_value({fill_valid, fill_done, fill_busy}, 0, "fill status in reset");
            check_value({store_done, store_busy}, 0, "store status in reset");
        end
        rst_n = 1'b1;
    endtask

    // Kind bit 0 store, bit 1 fill, bit 2 fill words given in the record.
    task automatic run_command(input int idx);
        logic [31:0] kind;
        logic [31:0] line_addr;
        int          base;
        base = idx * REC_WORDS;
        kind = cmd_mem[base];
        if (kind[0]) begin
            exp_store_haddr = sram_index(cmd_mem[base + 1]);
            exp_store_data  = cmd_mem[base + 2][15:0];
            exp_store_sel   = cmd_mem[base + 3][1:0];
            shadow_mem[exp_store_haddr] = merge_lanes(shadow_mem[exp_store_haddr],
                                                      exp_store_data, exp_store_sel);
            store_writes  = 0;
            store_pending = 1'b1;
            store_en      = 1'b1;
            store_addr    = cmd_mem[base + 1];
            store_data    = exp_store_data;
            store_sel     = exp_store_sel;
        end
        if (kind[1]) begin
            line_addr     = cmd_mem[base + 4] & ~(LINE_BYTES - 1);
            exp_fill_base = sram_index(line_addr);
            for (int w = 0; w < LINE_WORDS; w++) begin
                if (kind[2]) exp_fill_words[w] = cmd_mem[base + 5 + w][15:0];
                else exp_fill_words[w] = shadow_mem[exp_fill_base + 20'(w)];
            end
            fill_words_seen = 0;
            fill_reads      = 0;
            fill_pending    = 1'b1;
            fill_req        = 1'b1;
            fill_addr       = cmd_mem[base + 4];
        end
        @(posedge clk);
        #1;
        store_en = 1'b0;
        fill_req = 1'b0;
        if (kind[0]) check_value(store_busy, 1, "store busy after request");
        if (kind[1]) check_value(fill_busy, 1, "fill busy after request");
        while (fill_pending || store_pending) begin
            @(posedge clk);
            #1;
        end
        if (kind[1]) check_value(fill_words_seen, LINE_WORDS, "fill word count");
        if (kind[1]) check_value(fill_reads, LINE_WORDS, "SRAM read count");
        if (kind[0]) check_value(store_writes, 1, "SRAM write count");
        @(posedge clk);
        #1;
        check_value({fill_busy, store_busy}, 0, "busy after command");
    endtask

    initial begin
        rst_n         = 1'b0;
        fill_req      = 1'b0;
        fill_addr     = '0;
        store_en      = 1'b0;
        store_addr    = '0;
        store_data    = '0;
        store_sel     = '0;
        fill_pending  = 1'b0;
        store_pending = 1'b0;
        error_count   = 0;
        cycle_count   = 0;
        load_commands();
        cycle_limit = 40 * n_cmds + 100;
        preload_memory();
        apply_reset();
        for (int i = 0; i < n_cmds; i++) begin
            run_command(i);
        end
        repeat (4) @(posedge clk);
        $display("Commands: %0d, errors: %0d", n_cmds, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : mem_subsys_tb

`default_nettype wire

//--- verification/mem_subsys_properties.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_properties (
    input logic clk,
    input logic i_rst_n,
    input logic i_sram_ce_n,
    input logic i_sram_oe_n,
    input logic i_sram_we_n,
    input logic i_fill_valid,
    input logic i_fill_done,
    input logic i_store_busy,
    input logic i_store_done
);

    // Never drive and read the SRAM at once.
    a_oe_we_exclusive: assert property (
        @(posedge clk) disable iff (!i_rst_n) !(!i_sram_oe_n && !i_sram_we_n)
    ) else $error("SRAM oe_n and we_n low in the same cycle");

    // Chip stays deselected through reset.
    a_ce_in_reset: assert property (
        @(posedge clk) !i_rst_n |=> i_sram_ce_n
    ) else $error("SRAM ce_n low during reset");

    a_fill_done_valid: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_fill_done |-> i_fill_valid
    ) else $error("fill done without a valid fill word");

    a_store_busy_drop: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_store_done |=> !i_store_busy
    ) else $error("store busy still high after store done");

endmodule : mem_subsys_properties

bind mem_subsys_top mem_subsys_properties mem_subsys_properties_inst (
    .clk(clk),
    .i_rst_n(i_rst_n),
    .i_sram_ce_n(o_sram_ce_n),
    .i_sram_oe_n(o_sram_oe_n),
    .i_sram_we_n(o_sram_we_n),
    .i_fill_valid(o_fill_valid),
    .i_fill_done(o_fill_done),
    .i_store_busy(o_store_busy),
    .i_store_done(o_store_done)
);

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter realtime HALF_PERIOD = 5.0
) (
    output logic o_clk
);

    // Free running, 10 ns period.
    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

endmodule : tb_clock_gen

`default_nettype wire

//--- design/mem_subsys_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top #(
    parameter int                        LINE_WORDS     = 4,
    parameter procyon_mem_pkg::wb_addr_t SRAM_BASE_ADDR = '0
) (
    input  logic                            clk,
    input  logic                            i_rst_n,

    // Cache line fill.
    input  logic                            i_fill_req,
    input  procyon_mem_pkg::wb_addr_t       i_fill_addr,
    output logic                            o_fill_valid,
    output procyon_mem_pkg::wb_data_t       o_fill_data,
    output logic [$clog2(LINE_WORDS)-1:0]   o_fill_index,
    output logic                            o_fill_done,
    output logic                            o_fill_busy,

    // Store drain.
    input  logic                            i_store_en,
    input  procyon_mem_pkg::wb_addr_t       i_store_addr,
    input  procyon_mem_pkg::wb_data_t       i_store_data,
    input  procyon_mem_pkg::wb_sel_t        i_store_sel,
    output logic                            o_store_busy,
    output logic                            o_store_done,

    // SRAM pins.
    input  procyon_mem_pkg::sram_data_t     i_sram_dq,
    output procyon_mem_pkg::sram_data_t     o_sram_dq,
    output procyon_mem_pkg::sram_addr_t     o_sram_addr,
    output logic                            o_sram_ce_n,
    output logic                            o_sram_oe_n,
    output logic                            o_sram_we_n,
    output logic                            o_sram_lb_n,
    output logic                            o_sram_ub_n
);

    wb_if fill_bus ();
    wb_if store_bus ();
    wb_if sram_bus ();

    mem_line_fill #(
        .LINE_WORDS(LINE_WORDS)
    ) mem_line_fill_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_fill_req(i_fill_req),
        .i_fill_addr(i_fill_addr),
        .bus(fill_bus),
        .o_fill_valid(o_fill_valid),
        .o_fill_data(o_fill_data),
        .o_fill_index(o_fill_index),
        .o_fill_done(o_fill_done),
        .o_fill_busy(o_fill_busy)
    );

    mem_store_drain mem_store_drain_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_store_en(i_store_en),
        .i_store_addr(i_store_addr),
        .i_store_data(i_store_data),
        .i_store_sel(i_store_sel),
        .bus(store_bus),
        .o_store_busy(o_store_busy),
        .o_store_done(o_store_done)
    );

    wb_arbiter wb_arbiter_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .fill_bus(fill_bus),
        .store_bus(store_bus),
        .sram_bus(sram_bus)
    );

    sram_wb #(
        .BASE_ADDR(SRAM_BASE_ADDR)
    ) sram_wb_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .bus(sram_bus),
        .i_sram_dq(i_sram_dq),
        .o_sram_dq(o_sram_dq),
        .o_sram_addr(o_sram_addr),
        .o_sram_ce_n(o_sram_ce_n),
        .o_sram_oe_n(o_sram_oe_n),
        .o_sram_we_n(o_sram_we_n),
        .o_sram_lb_n(o_sram_lb_n),
        .o_sram_ub_n(o_sram_ub_n)
    );

endmodule : mem_subsys_top

`default_nettype wire

//--- design/sram_wb.sv
`timescale 1ns/10ps
`default_nettype none

module sram_wb #(
    parameter procyon_mem_pkg::wb_addr_t BASE_ADDR = '0
) (
    input  logic                        clk,
    input  logic                        i_rst_n,

    wb_if.slave                         bus,

    input  procyon_mem_pkg::sram_data_t i_sram_dq,
    output procyon_mem_pkg::sram_data_t o_sram_dq,
    output procyon_mem_pkg::sram_addr_t o_sram_addr,
    output logic                        o_sram_ce_n,
    output logic                        o_sram_oe_n,
    output logic                        o_sram_we_n,
    output logic                        o_sram_lb_n,
    output logic                        o_sram_ub_n
);

    import procyon_mem_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACCESS,
        S_RECOVER
    } sram_state_t;

    sram_state_t state;
    wb_addr_t    offset;
    logic        start;

    // Byte offset from the SRAM window base.
    assign offset = bus.addr - BASE_ADDR;
    assign start  = (state == S_IDLE) && bus.cyc && bus.stb;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state       <= S_IDLE;
            bus.ack     <= 1'b0;
            o_sram_ce_n <= 1'b1;
            o_sram_oe_n <= 1'b1;
            o_sram_we_n <= 1'b1;
            o_sram_lb_n <= 1'b1;
            o_sram_ub_n <= 1'b1;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state       <= S_ACCESS;
                        o_sram_ce_n <= 1'b0;
                        o_sram_oe_n <= bus.we;
                        o_sram_we_n <= ~bus.we;
                        // Both lanes on reads.
                        o_sram_lb_n <= bus.we ? ~bus.sel[0] : 1'b0;
                        o_sram_ub_n <= bus.we ? ~bus.sel[1] : 1'b0;
                    end
                end
                S_ACCESS: begin
                    state       <= S_RECOVER;
                    bus.ack     <= 1'b1;
                    o_sram_ce_n <= 1'b1;
                    o_sram_oe_n <= 1'b1;
                    o_sram_we_n <= 1'b1;
                    o_sram_lb_n <= 1'b1;
                    o_sram_ub_n <= 1'b1;
                end
                S_RECOVER: begin
                    state   <= S_IDLE;
                    bus.ack <= 1'b0;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            o_sram_addr <= offset[SRAM_ADDR_WIDTH:1];
            o_sram_dq   <= bus.wdata;
        end
        if (state == S_ACCESS) begin
            bus.rdata <= i_sram_dq;
        end
    end

endmodule : sram_wb

`default_nettype wire

//--- design/wb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter (
    input  logic clk,
    input  logic i_rst_n,

    wb_if.slave  fill_bus,
    wb_if.slave  store_bus,
    wb_if.master sram_bus
);

    import procyon_mem_pkg::*;

    // last_winner is 1 for the store master; it keeps its value while idle.
    logic owner_vld;
    logic last_winner;
    logic owner_cyc;
    logic grant_store;
    logic fill_sel;
    logic store_sel;

    assign owner_cyc = last_winner ? store_bus.cyc : fill_bus.cyc;

    // On contention the master that lost last time goes first.
    assign grant_store = store_bus.cyc & (~fill_bus.cyc | ~last_winner);

    assign fill_sel  = owner_vld & ~last_winner;
    assign store_sel = owner_vld & last_winner;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            owner_vld   <= 1'b0;
            last_winner <= 1'b0;
        end else if (!owner_vld || !owner_cyc) begin
            owner_vld <= fill_bus.cyc | store_bus.cyc;
            if (fill_bus.cyc || store_bus.cyc) begin
                last_winner <= grant_store;
            end
        end
    end

    always_comb begin
        sram_bus.cyc   = 1'b0;
        sram_bus.stb   = 1'b0;
        sram_bus.we    = 1'b0;
        sram_bus.cti   = WB_CTI_CLASSIC;
        sram_bus.sel   = '0;
        sram_bus.addr  = '0;
        sram_bus.wdata = '0;
        if (fill_sel) begin
            sram_bus.cyc   = fill_bus.cyc;
            sram_bus.stb   = fill_bus.stb;
            sram_bus.we    = fill_bus.we;
            sram_bus.cti   = fill_bus.cti;
            sram_bus.sel   = fill_bus.sel;
            sram_bus.addr  = fill_bus.addr;
            sram_bus.wdata = fill_bus.wdata;
        end else if (store_sel) begin
            sram_bus.cyc   = store_bus.cyc;
            sram_bus.stb   = store_bus.stb;
            sram_bus.we    = store_bus.we;
            sram_bus.cti   = store_bus.cti;
            sram_bus.sel   = store_bus.sel;
            sram_bus.addr  = store_bus.addr;
            sram_bus.wdata = store_bus.wdata;
        end
    end

    // Responses go back to the owner only.
    assign fill_bus.ack    = fill_sel & sram_bus.ack;
    assign fill_bus.rdata  = fill_sel ? sram_bus.rdata : '0;
    assign store_bus.ack   = store_sel & sram_bus.ack;
    assign store_bus.rdata = store_sel ? sram_bus.rdata : '0;

endmodule : wb_arbiter

`default_nettype wire

//--- design/mem_store_drain.sv
`timescale 1ns/10ps
`default_nettype none

module mem_store_drain (
    input  logic                      clk,
    input  logic                      i_rst_n,

    input  logic                      i_store_en,
    input  procyon_mem_pkg::wb_addr_t i_store_addr,
    input  procyon_mem_pkg::wb_data_t i_store_data,
    input  procyon_mem_pkg::wb_sel_t  i_store_sel,

    wb_if.master                      bus,

    output logic                      o_store_busy,
    output logic                      o_store_done
);

    import procyon_mem_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE,
        S_DONE
    } store_state_t;

    store_state_t state;
    wb_addr_t     addr_q;
    wb_data_t     data_q;
    wb_sel_t      sel_q;

    assign o_store_busy = (state != S_IDLE);
    assign o_store_done = (state == S_DONE);

    // Single classic write cycle.
    assign bus.cyc   = (state == S_WRITE);
    assign bus.stb   = (state == S_WRITE);
    assign bus.we    = 1'b1;
    assign bus.cti   = WB_CTI_CLASSIC;
    assign bus.sel   = sel_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = data_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (i_store_en) state <= S_WRITE;
                S_WRITE: if (bus.ack) state <= S_DONE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && i_store_en) begin
            addr_q <= i_store_addr;
            data_q <= i_store_data;
            sel_q  <= i_store_sel;
        end
    end

endmodule : mem_store_drain

`default_nettype wire

//--- design/mem_line_fill.sv
`timescale 1ns/10ps
`default_nettype none

module mem_line_fill #(
    parameter int LINE_WORDS = 4
) (
    input  logic                            clk,
    input  logic                            i_rst_n,

    input  logic                            i_fill_req,
    input  procyon_mem_pkg::wb_addr_t       i_fill_addr,

    wb_if.master                            bus,

    output logic                            o_fill_valid,
    output procyon_mem_pkg::wb_data_t       o_fill_data,
    output logic [$clog2(LINE_WORDS)-1:0]   o_fill_index,
    output logic                            o_fill_done,
    output logic                            o_fill_busy
);

    import procyon_mem_pkg::*;

    localparam int               IDX_W      = $clog2(LINE_WORDS);
    localparam wb_addr_t         WORD_BYTES = wb_addr_t'(WB_SEL_WIDTH);
    localparam wb_addr_t         LINE_MASK  = ~(wb_addr_t'(LINE_WORDS) * WORD_BYTES - 1'b1);
    localparam logic [IDX_W-1:0] LAST_BEAT  = IDX_W'(LINE_WORDS - 1);

    typedef enum logic {
        S_IDLE,
        S_BURST
    } fill_state_t;

    fill_state_t      state;
    wb_addr_t         addr_q;
    logic [IDX_W-1:0] beat;
    logic             last_beat;

    assign last_beat   = (beat == LAST_BEAT);
    assign o_fill_busy = (state == S_BURST);

    // Read burst, held open until the final ack.
    assign bus.cyc   = (state == S_BURST);
    assign bus.stb   = (state == S_BURST);
    assign bus.we    = 1'b0;
    assign bus.cti   = last_beat ? WB_CTI_EOB : WB_CTI_INCR;
    assign bus.sel   = '1;
    assign bus.addr  = addr_q;
    assign bus.wdata = '0;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state        <= S_IDLE;
            beat         <= '0;
            o_fill_valid <= 1'b0;
            o_fill_done  <= 1'b0;
        end else begin
            o_fill_valid <= 1'b0;
            o_fill_done  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_fill_req) begin
                        state <= S_BURST;
                        beat  <= '0;
                    end
                end
                S_BURST: begin
                    if (bus.ack) begin
                        o_fill_valid <= 1'b1;
                        o_fill_done  <= last_beat;
                        beat         <= beat + 1'b1;
                        if (last_beat) begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && i_fill_req) begin
            addr_q <= i_fill_addr & LINE_MASK;
        end else if (state == S_BURST && bus.ack) begin
            addr_q       <= addr_q + WORD_BYTES;
            o_fill_data  <= bus.rdata;
            o_fill_index <= beat;
        end
    end

endmodule : mem_line_fill

`default_nettype wire

//--- design/wb_if.sv
`timescale 1ns/10ps
`default_nettype none

interface wb_if;

    import procyon_mem_pkg::*;

    logic     cyc;
    logic     stb;
    logic     we;
    wb_cti_t  cti;
    wb_sel_t  sel;
    wb_addr_t addr;
    wb_data_t wdata;
    wb_data_t rdata;
    logic     ack;

    modport master (
        output cyc, stb, we, cti, sel, addr, wdata,
        input  rdata, ack
    );

    modport slave (
        input  cyc, stb, we, cti, sel, addr, wdata,
        output rdata, ack
    );

endinterface : wb_if

`default_nettype wire

//--- design/procyon_mem_pkg.sv
`default_nettype none

package procyon_mem_pkg;

    localparam int WB_ADDR_WIDTH   = 32;
    localparam int WB_DATA_WIDTH   = 16;
    localparam int WB_SEL_WIDTH    = WB_DATA_WIDTH / 8;
    localparam int WB_CTI_WIDTH    = 3;

    localparam int SRAM_ADDR_WIDTH = 20;
    localparam int SRAM_DATA_WIDTH = 16;

    // Wishbone bus fields.
    typedef logic [WB_ADDR_WIDTH-1:0]   wb_addr_t;
    typedef logic [WB_DATA_WIDTH-1:0]   wb_data_t;
    typedef logic [WB_SEL_WIDTH-1:0]    wb_sel_t;

    // SRAM pins, halfword addressed.
    typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;
    typedef logic [SRAM_DATA_WIDTH-1:0] sram_data_t;

    // Cycle type identifiers, registered feedback subset.
    typedef enum logic [WB_CTI_WIDTH-1:0] {
        WB_CTI_CLASSIC = 3'b000,
        WB_CTI_INCR    = 3'b010,
        WB_CTI_EOB     = 3'b111
    } wb_cti_t;

endpackage : procyon_mem_pkg

`default_nettype wire
